/* common/pulse_pkg.sv */
package pulse_pkg;

  // Host word and assembled message widths
  localparam int XB_SIZE  = 32;
  localparam int MSG_SIZE = 3 * XB_SIZE;

  // Control message layout
  localparam int TYPE_BIT     = 0;  // 0 means control
  localparam int START_BIT    = 6;  // 1 start, 0 stop
  localparam int N_FRAME_BIT  = 8;
  localparam int N_FRAME_SIZE = 24;
  localparam int CLOCK_BIT    = N_FRAME_BIT + N_FRAME_SIZE;
  localparam int CLOCK_SIZE   = 24;
  localparam int STRIDE_BIT   = CLOCK_BIT + CLOCK_SIZE;
  localparam int STRIDE_SIZE  = 8;

  // Commands from the pacer to the RAM controller
  typedef enum logic [1:0] {
    CMD_SOF_WR = 2'd0,
    CMD_ENTRY  = 2'd1,
    CMD_EOF    = 2'd2,
    CMD_SOF_RD = 2'd3
  } ram_cmd_kind_t;

  typedef struct packed {
    ram_cmd_kind_t kind;
    logic [23:0]   payload;  // Entry value in low byte, or frame number
  } ram_cmd_t;

  // One per frame read pass
  typedef struct packed {
    logic [23:0] frame;
    logic [15:0] sum;
  } report_t;

  localparam logic [7:0] REPORT_HEADER = 8'hA5;

endpackage

/* logic/msg_assembler.sv */
`timescale 1ns/100ps

module msg_assembler (
  input  logic                                 CLK,
  input  logic                                 RESET,
  input  logic                                 pc_msg_valid,
  input  logic [pulse_pkg::XB_SIZE-1:0]        pc_msg,
  output logic                                 pc_msg_ack,
  output logic                                 start_msg,
  output logic                                 stop_msg,
  output logic                                 msg_error,
  output logic [pulse_pkg::N_FRAME_SIZE-1:0]   n_frame,
  output logic [pulse_pkg::CLOCK_SIZE-1:0]     clocks_per_frame,
  output logic [pulse_pkg::STRIDE_SIZE-1:0]    stride
);
  import pulse_pkg::*;

  logic [1:0]           word_cnt;
  logic [2*XB_SIZE-1:0] cache;  // First two words
  logic [MSG_SIZE-1:0]  msg;
  logic                 last_word;

  assign pc_msg_ack = pc_msg_valid;
  assign msg = {pc_msg, cache};
  assign last_word = pc_msg_valid && word_cnt == 2'd2;

  always_ff @(posedge CLK) begin
    if (pc_msg_valid && word_cnt == 2'd0) cache[0 +: XB_SIZE] <= pc_msg;
    if (pc_msg_valid && word_cnt == 2'd1) cache[XB_SIZE +: XB_SIZE] <= pc_msg;
    if (last_word) begin
      n_frame          <= msg[N_FRAME_BIT +: N_FRAME_SIZE];
      clocks_per_frame <= msg[CLOCK_BIT +: CLOCK_SIZE];
      stride           <= msg[STRIDE_BIT +: STRIDE_SIZE];
    end
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      word_cnt  <= 2'd0;
      start_msg <= 1'b0;
      stop_msg  <= 1'b0;
      msg_error <= 1'b0;
    end else begin
      if (pc_msg_valid) word_cnt <= (word_cnt == 2'd2) ? 2'd0 : word_cnt + 2'd1;
      start_msg <= last_word && !msg[TYPE_BIT] && msg[START_BIT];
      stop_msg  <= last_word && !msg[TYPE_BIT] && !msg[START_BIT];
      if (last_word && msg[TYPE_BIT]) msg_error <= 1'b1;  // Sticky
    end
  end

endmodule

/* logic/sync_fifo.sv */
`timescale 1ns/100ps

module sync_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 16
) (
  input  logic CLK,
  input  logic RESET,
  input  logic push,
  input  T     din,
  input  logic pop,
  output T     dout,
  output logic full,
  output logic empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_push;
  logic          do_pop;

  assign full    = count == (AW+1)'(DEPTH);
  assign empty   = count == '0;
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign dout    = mem[rd_ptr];  // Show-ahead

  always_ff @(posedge CLK) begin
    if (do_push) mem[wr_ptr] <= din;
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* pacer/pacer.sv */
`timescale 1ns/100ps

module pacer #(
  parameter int N_ZMW = 128
) (
  input  logic                                CLK,
  input  logic                                RESET,
  input  logic                                start_msg,
  input  logic                                stop_msg,
  input  logic [pulse_pkg::N_FRAME_SIZE-1:0]  n_frame,
  input  logic [pulse_pkg::CLOCK_SIZE-1:0]    clocks_per_frame,
  input  logic [pulse_pkg::STRIDE_SIZE-1:0]   stride,
  input  logic                                cmd_full,
  output logic                                cmd_push,
  output pulse_pkg::ram_cmd_t                 cmd_data,
  output logic                                app_running,
  output logic                                app_error
);
  import pulse_pkg::*;

  // Init sequence index: SOF-write, N_ZMW entries, EOF
  localparam int IDX_W = $clog2(N_ZMW + 2);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(N_ZMW + 1);

  typedef enum logic [2:0] {
    ST_STOPPED, ST_INIT, ST_INIT_PAUSED, ST_INTRAFRAME, ST_ERROR
  } state_t;

  state_t                   state;
  logic                     eof_pending;  // Stop seen, EOF not yet queued
  logic [IDX_W-1:0]         idx;
  logic [STRIDE_SIZE-1:0]   acc;
  logic [STRIDE_SIZE-1:0]   stride_r;
  logic [N_FRAME_SIZE-1:0]  max_frame;
  logic [N_FRAME_SIZE-1:0]  frame_cnt;
  logic [CLOCK_SIZE-1:0]    cpf;
  logic [CLOCK_SIZE-1:0]    clk_cnt;

  assign app_running = state inside {ST_INIT, ST_INIT_PAUSED, ST_INTRAFRAME};
  assign app_error   = state == ST_ERROR;

  always_comb begin
    cmd_push         = 1'b0;
    cmd_data.kind    = CMD_EOF;
    cmd_data.payload = '0;
    case (state)
      ST_STOPPED: cmd_push = eof_pending && !cmd_full;
      ST_INIT: begin
        cmd_push = !stop_msg && !cmd_full;
        if (idx == '0) begin
          cmd_data.kind = CMD_SOF_WR;
        end else if (idx != LAST_IDX) begin
          cmd_data.kind    = CMD_ENTRY;
          cmd_data.payload = {16'd0, acc};
        end
      end
      ST_INTRAFRAME: begin
        cmd_push         = !stop_msg && !cmd_full && clk_cnt == '0;  // Frame start
        cmd_data.kind    = CMD_SOF_RD;
        cmd_data.payload = frame_cnt;
      end
      default: cmd_push = 1'b0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state       <= ST_STOPPED;
      eof_pending <= 1'b0;
    end else begin
      case (state)
        ST_STOPPED:
          if (eof_pending) begin
            if (!cmd_full) eof_pending <= 1'b0;
          end else if (start_msg) begin
            state     <= ST_INIT;
            idx       <= '0;
            acc       <= '0;
            stride_r  <= stride;
            max_frame <= n_frame;
            cpf       <= clocks_per_frame;
          end
        ST_INIT:
          if (stop_msg) begin
            state       <= ST_STOPPED;
            eof_pending <= 1'b1;
          end else if (cmd_full) begin
            state <= ST_INIT_PAUSED;
          end else begin
            idx <= idx + 1'b1;
            if (idx != '0) acc <= acc + stride_r;  // Entry k is k*stride mod 256
            if (idx == LAST_IDX) begin
              clk_cnt   <= '0;
              frame_cnt <= '0;
              state     <= (max_frame == '0) ? ST_STOPPED : ST_INTRAFRAME;
            end
          end
        ST_INIT_PAUSED:
          if (stop_msg) begin
            state       <= ST_STOPPED;
            eof_pending <= 1'b1;
          end else if (!cmd_full) begin
            state <= ST_INIT;
          end
        ST_INTRAFRAME:
          if (stop_msg) begin
            state       <= ST_STOPPED;
            eof_pending <= 1'b1;
          end else if (clk_cnt == '0 && cmd_full) begin
            state <= ST_ERROR;  // Overrun
          end else if (clk_cnt + 1'b1 >= cpf) begin
            clk_cnt <= '0;
            if (frame_cnt + 1'b1 >= max_frame) state <= ST_STOPPED;
            else frame_cnt <= frame_cnt + 1'b1;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        default: state <= ST_ERROR;  // Held until reset
      endcase
    end
  end

endmodule

/* pulse_ram/pulse_ram_ctrl.sv */
`timescale 1ns/100ps

module pulse_ram_ctrl #(
  parameter int N_ZMW      = 128,
  parameter int READ_DELAY = 3
) (
  input  logic                 CLK,
  input  logic                 RESET,
  input  logic                 cmd_empty,
  input  pulse_pkg::ram_cmd_t  cmd_data,
  output logic                 cmd_pop,
  output logic                 rpt_push,
  output pulse_pkg::report_t   rpt_data
);
  import pulse_pkg::*;

  localparam int AW = $clog2(N_ZMW);

  typedef enum logic [1:0] {ST_IDLE, ST_WR_WAIT, ST_READING} state_t;

  state_t                  state;
  logic [7:0]              ram [N_ZMW];
  logic [AW-1:0]           wr_addr;
  logic [AW-1:0]           rd_addr;
  logic [AW-1:0]           rx_cnt;   // Words out of the read pipeline
  logic                    issuing;
  logic [READ_DELAY-1:0]   pipe_vld;
  logic [7:0]              pipe_data [READ_DELAY];
  logic [7:0]              rd_word;
  logic [23:0]             frame_r;
  logic [15:0]             sum_r;
  logic                    wr_en;
  logic                    last_word;

  assign cmd_pop   = !cmd_empty && (state == ST_IDLE || state == ST_WR_WAIT);
  assign wr_en     = cmd_pop && state == ST_WR_WAIT && cmd_data.kind == CMD_ENTRY;
  assign rd_word   = pipe_data[READ_DELAY-1];
  assign last_word = pipe_vld[READ_DELAY-1] && rx_cnt == AW'(N_ZMW - 1);

  // Report leaves with the last delayed word
  assign rpt_push       = last_word;
  assign rpt_data.frame = frame_r;
  assign rpt_data.sum   = sum_r + {8'd0, rd_word};

  always_ff @(posedge CLK) begin
    if (wr_en) ram[wr_addr] <= cmd_data.payload[7:0];
    pipe_data[0] <= ram[rd_addr];
    for (int i = 1; i < READ_DELAY; i++) pipe_data[i] <= pipe_data[i-1];
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state    <= ST_IDLE;
      issuing  <= 1'b0;
      pipe_vld <= '0;
    end else begin
      pipe_vld[0] <= issuing;
      for (int i = 1; i < READ_DELAY; i++) pipe_vld[i] <= pipe_vld[i-1];
      case (state)
        ST_IDLE:
          if (cmd_pop) begin
            if (cmd_data.kind == CMD_SOF_WR) begin
              state   <= ST_WR_WAIT;
              wr_addr <= '0;
            end else if (cmd_data.kind == CMD_SOF_RD) begin
              state   <= ST_READING;
              frame_r <= cmd_data.payload;
              rd_addr <= '0;
              rx_cnt  <= '0;
              sum_r   <= '0;
              issuing <= 1'b1;
            end
          end
        ST_WR_WAIT:
          if (cmd_pop) begin
            case (cmd_data.kind)
              CMD_ENTRY:  wr_addr <= wr_addr + 1'b1;
              CMD_SOF_WR: wr_addr <= '0;  // Restarted list
              default:    state <= ST_IDLE;
            endcase
          end
        ST_READING: begin
          if (issuing) begin
            rd_addr <= rd_addr + 1'b1;
            if (rd_addr == AW'(N_ZMW - 1)) issuing <= 1'b0;
          end
          if (pipe_vld[READ_DELAY-1]) begin
            sum_r  <= sum_r + {8'd0, rd_word};
            rx_cnt <= rx_cnt + 1'b1;
          end
          if (last_word) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* logic/report_serializer.sv */
`timescale 1ns/100ps

module report_serializer (
  input  logic                            CLK,
  input  logic                            RESET,
  input  logic                            rpt_empty,
  input  pulse_pkg::report_t              rpt_data,
  output logic                            rpt_pop,
  output logic                            fpga_msg_valid,
  output logic [pulse_pkg::XB_SIZE-1:0]   fpga_msg
);
  import pulse_pkg::*;

  logic        send_w1;  // Sum word due next
  logic [15:0] sum_r;

  // No pop while the header word is on the bus
  assign rpt_pop = !rpt_empty && !send_w1;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      fpga_msg_valid <= 1'b0;
      send_w1        <= 1'b0;
    end else begin
      fpga_msg_valid <= rpt_pop || send_w1;
      send_w1        <= rpt_pop;
    end
  end

  always_ff @(posedge CLK) begin
    if (rpt_pop) begin
      fpga_msg <= {REPORT_HEADER, rpt_data.frame};
      sum_r    <= rpt_data.sum;
    end else if (send_w1) begin
      fpga_msg <= XB_SIZE'(sum_r);
    end
  end

endmodule

/* logic/application.sv */
`timescale 1ns/100ps

module application #(
  parameter int N_ZMW      = 128,
  parameter int FIFO_DEPTH = 16,
  parameter int READ_DELAY = 3
) (
  input  logic                            CLK,
  input  logic                            RESET,
  input  logic                            pc_msg_valid,
  input  logic [pulse_pkg::XB_SIZE-1:0]   pc_msg,
  output logic                            pc_msg_ack,
  output logic                            fpga_msg_valid,
  output logic [pulse_pkg::XB_SIZE-1:0]   fpga_msg,
  output logic                            app_running,
  output logic                            app_error,
  output logic                            msg_error
);
  import pulse_pkg::*;

  logic                     start_msg;
  logic                     stop_msg;
  logic [N_FRAME_SIZE-1:0]  n_frame;
  logic [CLOCK_SIZE-1:0]    clocks_per_frame;
  logic [STRIDE_SIZE-1:0]   stride;
  logic                     cmd_push;
  logic                     cmd_pop;
  logic                     cmd_full;
  logic                     cmd_empty;
  ram_cmd_t                 cmd_in;
  ram_cmd_t                 cmd_out;
  logic                     rpt_push;
  logic                     rpt_pop;
  logic                     rpt_empty;
  report_t                  rpt_in;
  report_t                  rpt_out;

  msg_assembler msg_assembler_i (
    .CLK, .RESET, .pc_msg_valid, .pc_msg, .pc_msg_ack,
    .start_msg, .stop_msg, .msg_error, .n_frame, .clocks_per_frame, .stride
  );

  pacer #(.N_ZMW(N_ZMW)) pacer_i (
    .CLK, .RESET, .start_msg, .stop_msg, .n_frame, .clocks_per_frame, .stride,
    .cmd_full, .cmd_push, .cmd_data(cmd_in), .app_running, .app_error
  );

  sync_fifo #(.T(ram_cmd_t), .DEPTH(FIFO_DEPTH)) cmd_fifo_i (
    .CLK, .RESET, .push(cmd_push), .din(cmd_in), .pop(cmd_pop),
    .dout(cmd_out), .full(cmd_full), .empty(cmd_empty)
  );

  pulse_ram_ctrl #(.N_ZMW(N_ZMW), .READ_DELAY(READ_DELAY)) pulse_ram_ctrl_i (
    .CLK, .RESET, .cmd_empty, .cmd_data(cmd_out), .cmd_pop,
    .rpt_push, .rpt_data(rpt_in)
  );

  // Report FIFO drains faster than frames arrive
  sync_fifo #(.T(report_t), .DEPTH(FIFO_DEPTH)) rpt_fifo_i (
    .CLK, .RESET, .push(rpt_push), .din(rpt_in), .pop(rpt_pop),
    .dout(rpt_out), .full(), .empty(rpt_empty)
  );

  report_serializer report_serializer_i (
    .CLK, .RESET, .rpt_empty, .rpt_data(rpt_out), .rpt_pop,
    .fpga_msg_valid, .fpga_msg
  );

endmodule

/* testbench/application_asserts.sv */
`timescale 1ns/100ps

module application_asserts (
  input logic        CLK,
  input logic        RESET,
  input logic        pc_msg_valid,
  input logic        pc_msg_ack,
  input logic        fpga_msg_valid,
  input logic [31:0] fpga_msg,
  input logic        app_running,
  input logic        app_error
);

  int   assert_failures = 0;
  logic sum_due;  // Header sent, sum word next

  always_ff @(posedge CLK) begin
    if (RESET) sum_due <= 1'b0;
    else if (fpga_msg_valid) sum_due <= !sum_due;
  end

  header_first: assert property (@(posedge CLK) disable iff (RESET)
    fpga_msg_valid && !sum_due |-> fpga_msg[31:24] == 8'hA5)
    else begin
      $error("Report started without the header value");
      assert_failures++;
    end

  sum_follows_header: assert property (@(posedge CLK) disable iff (RESET)
    fpga_msg_valid && !sum_due |=> fpga_msg_valid && fpga_msg[31:16] == 16'd0)
    else begin
      $error("Header word was not followed by a sum word");
      assert_failures++;
    end

  running_or_error: assert property (@(posedge CLK) !(app_running && app_error))
    else begin
      $error("app_running and app_error are high together");
      assert_failures++;
    end

  ack_is_valid: assert property (@(posedge CLK) pc_msg_ack == pc_msg_valid)
    else begin
      $error("pc_msg_ack differs from pc_msg_valid");
      assert_failures++;
    end

endmodule

/* testbench/application_checker.sv */
`timescale 1ns/100ps

module application_checker (
  input  logic         CLK,
  input  logic         RESET,
  input  logic         fpga_msg_valid,
  input  logic [31:0]  fpga_msg,
  input  logic         app_running,
  input  logic         app_error,
  input  logic         msg_error,
  input  logic [127:0] test_name,
  input  logic [1:0]   test_kind,
  input  int           exp_reports,  // Below zero accepts any count
  input  logic [15:0]  exp_sum,
  input  logic         exp_error,
  input  logic         test_done,
  output int           report_count,
  output int           check_count,
  output int           error_count
);

  localparam logic [1:0] KIND_DATA = 2'd3;
  localparam logic [7:0] HEADER    = 8'hA5;

  logic        sum_next;  // Second word of a report due
  logic [23:0] next_frame;
  logic        run_seen;
  logic        error_seen;

  initial begin
    check_count = 0;
    error_count = 0;
  end

  task automatic compare_value(input string what, input int expected, input int actual);
    check_count = check_count + 1;
    if (expected != actual) begin
      error_count = error_count + 1;
      $display("[ERROR] %0s: %0s expected %0d actual %0d",
               test_name, what, expected, actual);
    end
  endtask

  task automatic report_failure(input string text);
    error_count = error_count + 1;
    $display("Test %0s failed: %0s", test_name, text);
  endtask

  task automatic check_test_end();
    if (exp_reports > 0 && report_count == 0)
      report_failure("missing report, no report arrived");
    else if (exp_reports >= 0)
      compare_value("report count", exp_reports, report_count);
    compare_value("app_error", int'(exp_error), int'(app_error));
    compare_value("app_running", 0, int'(app_running));
    compare_value("msg_error", int'(test_kind == KIND_DATA), int'(msg_error));
    if (test_kind == KIND_DATA && run_seen) report_failure("a data message started a run");
  endtask

  always @(posedge CLK) begin
    if (RESET) begin
      sum_next     <= 1'b0;
      next_frame   <= '0;
      run_seen     <= 1'b0;
      error_seen   <= 1'b0;
      report_count <= 0;
    end else begin
      if (app_running) run_seen <= 1'b1;
      if (app_error) error_seen <= 1'b1;
      if (error_seen && !app_error) begin
        report_failure("app_error fell before reset");
        error_seen <= 1'b0;
      end
      if (fpga_msg_valid) begin
        if (!sum_next) begin
          compare_value("report header", int'(HEADER), int'(fpga_msg[31:24]));
          compare_value("frame number", int'(next_frame), int'(fpga_msg[23:0]));
        end else begin
          compare_value("report sum", int'(exp_sum), int'(fpga_msg));
          report_count <= report_count + 1;
          next_frame   <= next_frame + 1'b1;
        end
        sum_next <= !sum_next;
      end
      if (test_done) check_test_end();
    end
  end

endmodule

/* testbench/application_tb.sv */
`timescale 1ns/100ps

module application_tb;

  localparam int         N_ZMW        = 128;
  localparam int         MAX_TESTS    = 16;
  localparam int         HOLD_CYCLES  = 40;  // Error must persist this long
  localparam int         DRAIN_CYCLES = 20;
  localparam logic [1:0] KIND_RUN     = 2'd0;
  localparam logic [1:0] KIND_STOP    = 2'd1;
  localparam logic [1:0] KIND_OVERRUN = 2'd2;
  localparam logic [1:0] KIND_DATA    = 2'd3;

  logic         CLK;
  logic         RESET;
  logic         pc_msg_valid;
  logic [31:0]  pc_msg;
  logic         pc_msg_ack;
  logic         fpga_msg_valid;
  logic [31:0]  fpga_msg;
  logic         app_running;
  logic         app_error;
  logic         msg_error;

  // Expected values handed to the checker
  logic [127:0] test_name;
  logic [1:0]   test_kind;
  int           exp_reports;
  logic [15:0]  exp_sum;
  logic         exp_error;
  logic         test_done;
  int           report_count;
  int           check_count;
  int           error_count;

  logic [127:0] t_name [MAX_TESTS];
  logic [1:0]   t_kind [MAX_TESTS];
  int           t_frames [MAX_TESTS];
  int           t_cpf [MAX_TESTS];
  int           t_stride [MAX_TESTS];
  int           t_reports [MAX_TESTS];
  int           t_sum [MAX_TESTS];
  int           t_error [MAX_TESTS];
  int           n_tests = 0;
  int           tests_run = 0;
  int           cycle_cnt = 0;
  int           cycle_limit = 0;
  logic [31:0]  rng_state;

  application #(.N_ZMW(N_ZMW), .FIFO_DEPTH(16), .READ_DELAY(3)) application_i (
    .CLK, .RESET, .pc_msg_valid, .pc_msg, .pc_msg_ack,
    .fpga_msg_valid, .fpga_msg, .app_running, .app_error, .msg_error
  );

  application_checker checker_i (
    .CLK, .RESET, .fpga_msg_valid, .fpga_msg, .app_running, .app_error, .msg_error,
    .test_name, .test_kind, .exp_reports, .exp_sum, .exp_error, .test_done,
    .report_count, .check_count, .error_count
  );

  bind application application_asserts asserts_i (
    .CLK(CLK), .RESET(RESET), .pc_msg_valid(pc_msg_valid), .pc_msg_ack(pc_msg_ack),
    .fpga_msg_valid(fpga_msg_valid), .fpga_msg(fpga_msg),
    .app_running(app_running), .app_error(app_error)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
      abort_run($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [1:0] kind_code(input logic [127:0] kind);
    if (kind == 128'("stop")) return KIND_STOP;
    if (kind == 128'("overrun")) return KIND_OVERRUN;
    if (kind == 128'("data")) return KIND_DATA;
    return KIND_RUN;
  endfunction

  function automatic int total_errors();
    return error_count + application_i.asserts_i.assert_failures;
  endfunction

  task automatic load_tests();
    int           fd;
    string        line;
    logic [127:0] nm;
    logic [127:0] kd;
    int           f;
    int           c;
    int           s;
    int           r;
    int           sm;
    int           e;
    fd = $fopen("testbench/application_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open testbench/application_tests.txt");
    end else begin
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#" &&
            $sscanf(line, "%s %s %d %d %d %d %d %d", nm, kd, f, c, s, r, sm, e) == 8) begin
          t_name[n_tests]    = nm;
          t_kind[n_tests]    = kind_code(kd);
          t_frames[n_tests]  = f;
          t_cpf[n_tests]     = c;
          t_stride[n_tests]  = s;
          t_reports[n_tests] = r;
          t_sum[n_tests]     = sm;
          t_error[n_tests]   = e;
          n_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic apply_reset();
    @(posedge CLK);
    RESET <= 1'b1;
    repeat (2) @(posedge CLK);
    RESET <= 1'b0;
  endtask

  // Three host words carry flags and frame count, clocks and stride, exposure
  task automatic send_control(input logic typ, input logic start, input int i);
    logic [31:0] words [3];
    words[0] = {t_frames[i][23:0], 1'b0, start, 5'd0, typ};
    words[1] = {t_stride[i][7:0], t_cpf[i][23:0]};
    rng_state = xorshift32(rng_state);
    words[2] = rng_state;  // Exposure is ignored
    for (int w = 0; w < 3; w++) begin
      @(posedge CLK);
      pc_msg_valid <= 1'b1;
      pc_msg       <= words[w];
    end
    @(posedge CLK);
    pc_msg_valid <= 1'b0;
  endtask

  task automatic run_test(input int i);
    test_name   <= t_name[i];
    test_kind   <= t_kind[i];
    exp_reports <= t_reports[i];
    exp_sum     <= t_sum[i][15:0];
    exp_error   <= t_error[i] != 0;
    apply_reset();
    case (t_kind[i])
      KIND_STOP: begin
        send_control(1'b0, 1'b1, i);
        while (!app_running) @(posedge CLK);
        send_control(1'b0, 1'b0, i);  // Lands while the list is written
        while (app_running) @(posedge CLK);
      end
      KIND_OVERRUN: begin
        send_control(1'b0, 1'b1, i);
        while (!app_error) @(posedge CLK);
        repeat (HOLD_CYCLES) @(posedge CLK);
      end
      KIND_DATA: begin
        send_control(1'b1, 1'b1, i);
        while (!msg_error) @(posedge CLK);
      end
      default: begin
        send_control(1'b0, 1'b1, i);
        while (!app_running) @(posedge CLK);
        while (app_running || report_count < t_reports[i]) @(posedge CLK);
      end
    endcase
    repeat (DRAIN_CYCLES) @(posedge CLK);  // Catch stray reports
    test_done <= 1'b1;
    @(posedge CLK);
    test_done <= 1'b0;
    @(posedge CLK);  // Checker finishes its end-of-test compares
    tests_run++;
  endtask

  task automatic print_summary();
    $display("Tests: %0d  checks: %0d  errors: %0d  assertion failures: %0d",
             tests_run, check_count, error_count, application_i.asserts_i.assert_failures);
  endtask

  task automatic abort_run(input string why);
    $display("%0s", why);
    print_summary();
    $display("Done: errors found");
    $finish;
  endtask

  task automatic finish_run();
    print_summary();
    if (total_errors() == 0) $display("Done: no errors");
    else $display("Done: errors found");
    $finish;
  endtask

  initial begin
    RESET        <= 1'b1;
    pc_msg_valid <= 1'b0;
    pc_msg       <= '0;
    test_done    <= 1'b0;
    rng_state = 32'hb213;
    load_tests();
    for (int i = 0; i < n_tests; i++) cycle_limit += t_frames[i] * t_cpf[i] + 400;
    if (n_tests == 0) begin
      abort_run("No tests were read from testbench/application_tests.txt");
    end else begin
      for (int i = 0; i < n_tests; i++) run_test(i);
      finish_run();
    end
  end

endmodule

/* testbench/application_tests.txt */
# name kind n_frame clocks_per_frame stride reports sum app_error
# kind is run, stop, overrun or data; reports -1 accepts any count
run_stride1      run      3   300  1    3   8128   0
run_stride3      run      2   250  3    2   13632  0
run_stride255    run      4   200  255  4   24384  0
stop_in_init     stop     3   300  1    0   0      0
overrun_short    overrun  40  10   1    -1  8128   1
data_message     data     1   100  1    0   0      0

/* build.f */
common/pulse_pkg.sv
logic/msg_assembler.sv
logic/sync_fifo.sv
pacer/pacer.sv
pulse_ram/pulse_ram_ctrl.sv
logic/report_serializer.sv
logic/application.sv
testbench/application_asserts.sv
testbench/application_checker.sv
testbench/application_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= application_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
